/* src.f */
design/noc_chain_pkg.sv
design/flit_packer.sv
design/flit_unpacker.sv
design/chain_router.sv
design/traffic_processor.sv
design/noc_chain_top.sv
tb/tb_noc_chain.sv

/* run.sh */
#!/bin/sh
# Compile and run the NoC chain testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_noc_chain \
    -f src.f \
    -o sim_noc_chain
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_noc_chain > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

/* tb/tb_noc_chain.sv */
// NoC chain testbench
`timescale 1ns/1ps

module tb_noc_chain;
    import noc_chain_pkg::*;

    // One table row holds a word and its group controls
    typedef struct packed {
        data_word_t data;
        node_addr_t dest;
        logic       stall;
        logic       mixed;
        logic       last;
    } stim_t;

    localparam int n_stim     = 27;
    localparam int max_cycles = n_stim * 40 + 200;

    // The chain drains after each row with last set
    // In the mixed group all dest 3 rows precede the dest 2 rows, and a dest 2 row closes it
    stim_t stim [n_stim] = '{
        '{64'h0123_4567_89ab_cdef, 3'd5, 1'b0, 1'b0, 1'b0},
        '{64'hdead_beef_0000_0001, 3'd6, 1'b0, 1'b0, 1'b0},
        '{64'h0000_0000_0000_0000, 3'd7, 1'b0, 1'b0, 1'b0},
        '{64'hffff_ffff_ffff_ffff, 3'd5, 1'b0, 1'b0, 1'b1},
        '{64'h0000_0000_0000_0010, 3'd4, 1'b0, 1'b0, 1'b0},
        '{64'hffff_ffff_ffff_fff8, 3'd4, 1'b0, 1'b0, 1'b0},
        '{64'h0000_0000_0000_0123, 3'd4, 1'b0, 1'b0, 1'b1},
        '{64'h0000_0000_0000_0001, 3'd2, 1'b0, 1'b0, 1'b0},
        '{64'h0000_0000_0000_0002, 3'd2, 1'b0, 1'b0, 1'b0},
        '{64'h1000_0000_0000_0003, 3'd2, 1'b0, 1'b0, 1'b1},
        '{64'h5555_5555_5555_5555, 3'd0, 1'b0, 1'b0, 1'b0},
        '{64'haaaa_aaaa_aaaa_aaaa, 3'd1, 1'b0, 1'b0, 1'b1},
        '{64'h0000_0000_0000_0100, 3'd3, 1'b0, 1'b1, 1'b0},
        '{64'h0000_0000_0000_0200, 3'd3, 1'b0, 1'b1, 1'b0},
        '{64'h0000_0000_0000_0030, 3'd4, 1'b0, 1'b1, 1'b0},
        '{64'h0000_0000_0000_0004, 3'd2, 1'b0, 1'b1, 1'b0},
        '{64'h0bad_cafe_0000_0006, 3'd6, 1'b0, 1'b1, 1'b0},
        '{64'h0000_0000_0000_0050, 3'd4, 1'b0, 1'b1, 1'b0},
        '{64'h0000_0000_0000_0007, 3'd2, 1'b0, 1'b1, 1'b1},
        '{64'h1111_2222_3333_4444, 3'd7, 1'b1, 1'b0, 1'b0},
        '{64'h0000_0000_0000_0009, 3'd4, 1'b1, 1'b0, 1'b0},
        '{64'h8000_0000_0000_0000, 3'd5, 1'b1, 1'b0, 1'b0},
        '{64'h8000_0000_0000_0001, 3'd4, 1'b1, 1'b0, 1'b0},
        '{64'h0f0f_0f0f_0f0f_0f0f, 3'd6, 1'b1, 1'b0, 1'b1},
        '{64'h0000_0000_0000_000b, 3'd2, 1'b1, 1'b0, 1'b0},
        '{64'h0000_0000_0000_000c, 3'd2, 1'b1, 1'b0, 1'b0},
        '{64'h0000_0000_0000_000d, 3'd2, 1'b1, 1'b0, 1'b1}
    };

    logic       clk;
    logic       reset;
    data_word_t in_data;
    node_addr_t in_dest;
    logic       in_valid;
    logic       in_ready;
    noc_flit_t  out_flit;
    logic       out_valid;
    logic       out_ready;
    logic       bad_dest;

    // Reference model with one accumulator per processing node
    data_word_t acc2;
    data_word_t acc3;
    data_word_t acc4;
    noc_flit_t  pass_q [$];
    data_word_t res_data [$];
    logic       res_exact [$];

    logic      stall_mode = 1'b0;
    logic      prev_stall = 1'b0;
    noc_flit_t prev_flit;
    int        err_value  = 0;
    int        err_other  = 0;
    int        seen_drops = 0;
    int        exp_drops  = 0;
    int        cycles     = 0;

    noc_chain_top i_noc_chain_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Random back-pressure only in stalled groups
    initial begin
        void'($urandom(32'hb366_b36f));
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (stall_mode) begin
                out_ready = ($urandom % 3) != 0;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // Each word runs down the chain to completion in the model
    task automatic model_word(input stim_t s);
        data_word_t v;
        noc_flit_t  f;
        if (s.dest < 3'd2) begin
            exp_drops++;
        end else if (s.dest > num_nodes) begin
            f = '{dest: s.dest, src: ingress_addr, data: s.data};
            pass_q.push_back(f);
        end else begin
            v = s.data;
            if (s.dest == 3'd2) begin
                acc2 = acc2 + v;
                v    = acc2;
            end
            if (s.dest <= 3'd3) begin
                acc3 = acc3 + v;
                v    = acc3;
            end
            acc4 = acc4 + v;
            res_data.push_back(acc4);
            // Mixed traffic only pins the final total
            res_exact.push_back(!s.mixed || s.last);
        end
    endtask

    task automatic send_word(input stim_t s);
        logic taken;
        in_data  = s.data;
        in_dest  = s.dest;
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            // in_ready is registered, so its value now holds for the next edge
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pass_q.size() != 0 || res_data.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_output(input noc_flit_t f);
        noc_flit_t  exp_flit;
        data_word_t exp_sum;
        logic       exact;
        if (f.src == ingress_addr) begin
            if (pass_q.size() == 0) begin
                $display("Unexpected pass-through flit %h on the output", f);
                err_other++;
            end else begin
                exp_flit = pass_q.pop_front();
                if (f !== exp_flit) begin
                    $display("[ERROR] out_flit got %h expected %h", f, exp_flit);
                    err_value++;
                end
            end
        end else if (f.src == num_nodes) begin
            if (res_data.size() == 0) begin
                $display("Unexpected result flit %h on the output", f);
                err_other++;
            end else begin
                exp_sum = res_data.pop_front();
                exact   = res_exact.pop_front();
                if (f.dest !== num_nodes + 3'd1) begin
                    $display("[ERROR] out_flit.dest got %h expected %h", f.dest,
                             num_nodes + 3'd1);
                    err_value++;
                end
                if (exact && f.data !== exp_sum) begin
                    $display("[ERROR] out_flit.data got %h expected %h", f.data, exp_sum);
                    err_value++;
                end
            end
        end else begin
            $display("Output flit came from node %0d, which sends nothing off the chain", f.src);
            err_other++;
        end
    endtask

    // Output monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (prev_stall && (!out_valid || out_flit !== prev_flit)) begin
                $display("Output flit changed or was withdrawn while out_ready was low");
                err_other++;
            end
            if (out_valid && out_ready) begin
                check_output(out_flit);
            end
            if (bad_dest) begin
                seen_drops++;
            end
            prev_stall <= out_valid && !out_ready;
            prev_flit  <= out_flit;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, %0d pass and %0d result flits still expected",
                     cycles, pass_q.size(), res_data.size());
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int end_errors;
        end_errors = 0;
        reset    = 1'b1;
        in_data  = '0;
        in_dest  = '0;
        in_valid = 1'b0;
        acc2     = '0;
        acc3     = '0;
        acc4     = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (stim[i]) begin
            stall_mode = stim[i].stall;
            model_word(stim[i]);
            send_word(stim[i]);
            if (stim[i].last) begin
                wait_drain();
            end
        end
        stall_mode = 1'b0;
        // Room for late drop pulses and stray flits
        repeat (10) @(posedge clk);
        if (seen_drops != exp_drops) begin
            $display("[ERROR] bad_dest pulses got %h expected %h", seen_drops, exp_drops);
            end_errors++;
        end
        $display("Errors: %0d value, %0d other, %0d at end", err_value, err_other, end_errors);
        if (err_value + err_other + end_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* design/noc_chain_top.sv */
// Four node NoC chain
`timescale 1ns/1ps

module noc_chain_top (
    input  logic                      clk,
    input  logic                      reset,
    input  noc_chain_pkg::data_word_t in_data,
    input  noc_chain_pkg::node_addr_t in_dest,
    input  logic                      in_valid,
    output logic                      in_ready,
    output noc_chain_pkg::noc_flit_t  out_flit,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      bad_dest
);
    import noc_chain_pkg::*;

    // Link i runs from node i to node i+1
    noc_flit_t  link_flit [1:3];
    logic [3:1] link_valid;
    logic [3:1] link_ready;

    // Local adapter paths of nodes 2 to 4
    noc_flit_t  ej_flit [2:4];
    logic [4:2] ej_valid;
    logic [4:2] ej_ready;
    data_word_t rx_word [2:4];
    logic [4:2] rx_valid;
    logic [4:2] rx_ready;
    data_word_t sum_word [2:4];
    logic [4:2] sum_valid;
    logic [4:2] sum_ready;
    noc_flit_t  inj_flit [2:4];
    logic [4:2] inj_valid;
    logic [4:2] inj_ready;

    flit_packer #(.src_addr(ingress_addr)) n1 (
        .clk(clk), .reset(reset),
        .word_data(in_data), .word_dest(in_dest),
        .word_valid(in_valid), .word_ready(in_ready),
        .flit(link_flit[1]), .flit_valid(link_valid[1]), .flit_ready(link_ready[1])
    );

    chain_router #(.node_addr(3'd2)) r2 (
        .clk(clk), .reset(reset),
        .up_flit(link_flit[1]), .up_valid(link_valid[1]), .up_ready(link_ready[1]),
        .inj_flit(inj_flit[2]), .inj_valid(inj_valid[2]), .inj_ready(inj_ready[2]),
        .down_flit(link_flit[2]), .down_valid(link_valid[2]), .down_ready(link_ready[2]),
        .ej_flit(ej_flit[2]), .ej_valid(ej_valid[2]), .ej_ready(ej_ready[2]),
        .drop(bad_dest)
    );

    // Internal packers never address backward, so r3 and r4 never drop
    chain_router #(.node_addr(3'd3)) r3 (
        .clk(clk), .reset(reset),
        .up_flit(link_flit[2]), .up_valid(link_valid[2]), .up_ready(link_ready[2]),
        .inj_flit(inj_flit[3]), .inj_valid(inj_valid[3]), .inj_ready(inj_ready[3]),
        .down_flit(link_flit[3]), .down_valid(link_valid[3]), .down_ready(link_ready[3]),
        .ej_flit(ej_flit[3]), .ej_valid(ej_valid[3]), .ej_ready(ej_ready[3]),
        .drop()
    );

    chain_router #(.node_addr(num_nodes)) r4 (
        .clk(clk), .reset(reset),
        .up_flit(link_flit[3]), .up_valid(link_valid[3]), .up_ready(link_ready[3]),
        .inj_flit(inj_flit[4]), .inj_valid(inj_valid[4]), .inj_ready(inj_ready[4]),
        .down_flit(out_flit), .down_valid(out_valid), .down_ready(out_ready),
        .ej_flit(ej_flit[4]), .ej_valid(ej_valid[4]), .ej_ready(ej_ready[4]),
        .drop()
    );

    flit_unpacker u2 (
        .clk(clk), .reset(reset),
        .flit(ej_flit[2]), .flit_valid(ej_valid[2]), .flit_ready(ej_ready[2]),
        .word(rx_word[2]), .word_valid(rx_valid[2]), .word_ready(rx_ready[2])
    );

    flit_unpacker u3 (
        .clk(clk), .reset(reset),
        .flit(ej_flit[3]), .flit_valid(ej_valid[3]), .flit_ready(ej_ready[3]),
        .word(rx_word[3]), .word_valid(rx_valid[3]), .word_ready(rx_ready[3])
    );

    flit_unpacker u4 (
        .clk(clk), .reset(reset),
        .flit(ej_flit[4]), .flit_valid(ej_valid[4]), .flit_ready(ej_ready[4]),
        .word(rx_word[4]), .word_valid(rx_valid[4]), .word_ready(rx_ready[4])
    );

    traffic_processor p2 (
        .clk(clk), .reset(reset),
        .word_in(rx_word[2]), .in_valid(rx_valid[2]), .in_ready(rx_ready[2]),
        .sum_out(sum_word[2]), .sum_valid(sum_valid[2]), .sum_ready(sum_ready[2])
    );

    traffic_processor p3 (
        .clk(clk), .reset(reset),
        .word_in(rx_word[3]), .in_valid(rx_valid[3]), .in_ready(rx_ready[3]),
        .sum_out(sum_word[3]), .sum_valid(sum_valid[3]), .sum_ready(sum_ready[3])
    );

    traffic_processor p4 (
        .clk(clk), .reset(reset),
        .word_in(rx_word[4]), .in_valid(rx_valid[4]), .in_ready(rx_ready[4]),
        .sum_out(sum_word[4]), .sum_valid(sum_valid[4]), .sum_ready(sum_ready[4])
    );

    // Results go one node further down the chain
    flit_packer #(.src_addr(3'd2)) k2 (
        .clk(clk), .reset(reset),
        .word_data(sum_word[2]), .word_dest(3'd3),
        .word_valid(sum_valid[2]), .word_ready(sum_ready[2]),
        .flit(inj_flit[2]), .flit_valid(inj_valid[2]), .flit_ready(inj_ready[2])
    );

    flit_packer #(.src_addr(3'd3)) k3 (
        .clk(clk), .reset(reset),
        .word_data(sum_word[3]), .word_dest(num_nodes),
        .word_valid(sum_valid[3]), .word_ready(sum_ready[3]),
        .flit(inj_flit[3]), .flit_valid(inj_valid[3]), .flit_ready(inj_ready[3])
    );

    flit_packer #(.src_addr(num_nodes)) k4 (
        .clk(clk), .reset(reset),
        .word_data(sum_word[4]), .word_dest(node_addr_t'(num_nodes + 3'd1)),
        .word_valid(sum_valid[4]), .word_ready(sum_ready[4]),
        .flit(inj_flit[4]), .flit_valid(inj_valid[4]), .flit_ready(inj_ready[4])
    );

endmodule

/* design/traffic_processor.sv */
// Running sum processor
`timescale 1ns/1ps

module traffic_processor (
    input  logic                      clk,
    input  logic                      reset,
    input  noc_chain_pkg::data_word_t word_in,
    input  logic                      in_valid,
    output logic                      in_ready,
    output noc_chain_pkg::data_word_t sum_out,
    output logic                      sum_valid,
    input  logic                      sum_ready
);

    typedef enum logic {
        st_idle,
        st_hold
    } tp_state_t;

    tp_state_t state;

    assign in_ready  = state == st_idle;
    assign sum_valid = state == st_hold;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= st_idle;
            sum_out <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        // Wraps at 64 bits
                        sum_out <= sum_out + word_in;
                        state   <= st_hold;
                    end
                end
                st_hold: begin
                    if (sum_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // A presented sum is never withdrawn
    a_sum_held: assert property (@(posedge clk) disable iff (reset)
        $fell(sum_valid) |-> $past(sum_ready));

endmodule

/* design/chain_router.sv */
// Chain router node
`timescale 1ns/1ps

module chain_router #(
    parameter noc_chain_pkg::node_addr_t node_addr = 3'd2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  noc_chain_pkg::noc_flit_t up_flit,
    input  logic                     up_valid,
    output logic                     up_ready,
    input  noc_chain_pkg::noc_flit_t inj_flit,
    input  logic                     inj_valid,
    output logic                     inj_ready,
    output noc_chain_pkg::noc_flit_t down_flit,
    output logic                     down_valid,
    input  logic                     down_ready,
    output noc_chain_pkg::noc_flit_t ej_flit,
    output logic                     ej_valid,
    input  logic                     ej_ready,
    output logic                     drop
);

    logic up_eject;
    logic up_fwd;
    logic up_back;
    logic down_space;
    logic ej_space;
    logic rr_inj;
    logic up_fwd_fire;
    logic up_ej_fire;
    logic inj_fire;

    // Route by destination relative to this node
    assign up_eject = up_flit.dest == node_addr;
    assign up_fwd   = up_flit.dest > node_addr;
    assign up_back  = up_flit.dest < node_addr;

    assign down_space = !down_valid || down_ready;
    assign ej_space   = !ej_valid || ej_ready;

    // rr_inj set means the inject port wins a tie for the downstream link
    always_comb begin
        if (up_eject) begin
            up_ready = ej_space;
        end else if (up_fwd) begin
            up_ready = down_space && !(inj_valid && rr_inj);
        end else begin
            // Backward flits are always taken and thrown away
            up_ready = 1'b1;
        end
    end

    assign inj_ready = down_space && !(up_valid && up_fwd && !rr_inj);

    assign up_fwd_fire = up_valid && up_ready && up_fwd;
    assign up_ej_fire  = up_valid && up_ready && up_eject;
    assign inj_fire    = inj_valid && inj_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            down_valid <= 1'b0;
            ej_valid   <= 1'b0;
            rr_inj     <= 1'b0;
            drop       <= 1'b0;
        end else begin
            if (up_fwd_fire || inj_fire) begin
                down_valid <= 1'b1;
            end else if (down_ready) begin
                down_valid <= 1'b0;
            end
            if (up_ej_fire) begin
                ej_valid <= 1'b1;
            end else if (ej_ready) begin
                ej_valid <= 1'b0;
            end
            // Priority passes to the port that just lost
            if (up_fwd_fire) begin
                rr_inj <= 1'b1;
            end else if (inj_fire) begin
                rr_inj <= 1'b0;
            end
            drop <= up_valid && up_back;
        end
    end

    always_ff @(posedge clk) begin
        if (up_fwd_fire) begin
            down_flit <= up_flit;
        end else if (inj_fire) begin
            down_flit <= inj_flit;
        end
        if (up_ej_fire) begin
            ej_flit <= up_flit;
        end
    end

    // Only flits for this node reach the local adapter
    a_eject_dest: assert property (@(posedge clk) disable iff (reset)
        ej_valid |-> ej_flit.dest == node_addr);

endmodule

/* design/flit_unpacker.sv */
// Ejected flit unpacker
`timescale 1ns/1ps

module flit_unpacker (
    input  logic                      clk,
    input  logic                      reset,
    input  noc_chain_pkg::noc_flit_t  flit,
    input  logic                      flit_valid,
    output logic                      flit_ready,
    output noc_chain_pkg::data_word_t word,
    output logic                      word_valid,
    input  logic                      word_ready
);

    logic flit_fire;

    // Accept when empty or when the held word leaves this cycle
    assign flit_ready = !word_valid || word_ready;
    assign flit_fire  = flit_valid && flit_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            word_valid <= 1'b0;
        end else if (flit_fire) begin
            word_valid <= 1'b1;
        end else if (word_ready) begin
            word_valid <= 1'b0;
        end
    end

    // Header is dropped here
    always_ff @(posedge clk) begin
        if (flit_fire) begin
            word <= flit.data;
        end
    end

endmodule

/* design/flit_packer.sv */
// Word to flit packer
`timescale 1ns/1ps

module flit_packer #(
    parameter noc_chain_pkg::node_addr_t src_addr = noc_chain_pkg::ingress_addr
) (
    input  logic                      clk,
    input  logic                      reset,
    input  noc_chain_pkg::data_word_t word_data,
    input  noc_chain_pkg::node_addr_t word_dest,
    input  logic                      word_valid,
    output logic                      word_ready,
    output noc_chain_pkg::noc_flit_t  flit,
    output logic                      flit_valid,
    input  logic                      flit_ready
);
    import noc_chain_pkg::*;

    noc_flit_t new_flit;
    noc_flit_t skid_q;
    logic      skid_valid;
    logic      in_fire;
    logic      out_fire;
    logic      load_out;

    assign new_flit = '{dest: word_dest, src: src_addr, data: word_data};

    // Ready comes from the skid register only
    assign word_ready = !skid_valid;
    assign in_fire    = word_valid && word_ready;
    assign out_fire   = flit_valid && flit_ready;

    // Output register is free now or frees up on this edge
    assign load_out = in_fire && (!flit_valid || out_fire);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            // Skid entry moves up, output stays full
            if (out_fire) begin
                skid_valid <= 1'b0;
            end
        end else if (in_fire) begin
            flit_valid <= 1'b1;
            skid_valid <= !load_out;
        end else if (out_fire) begin
            flit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_valid && out_fire) begin
            flit <= skid_q;
        end else if (load_out) begin
            flit <= new_flit;
        end
        if (in_fire && !load_out) begin
            skid_q <= new_flit;
        end
    end

    // Stalled flit holds until taken
    a_flit_stable: assert property (@(posedge clk) disable iff (reset)
        flit_valid && !flit_ready |=> flit_valid && $stable(flit));

endmodule

/* design/noc_chain_pkg.sv */
// NoC chain shared types
package noc_chain_pkg;

    // Payload and address widths
    localparam int data_w = 64;
    localparam int addr_w = 3;

    typedef logic [data_w-1:0] data_word_t;

    // Node 1 is the ingress, 2 to 4 are routers, 5 to 7 lie beyond the chain
    typedef logic [addr_w-1:0] node_addr_t;

    // 70-bit flit with the header above the payload word
    typedef struct packed {
        node_addr_t dest;
        node_addr_t src;
        data_word_t data;
    } noc_flit_t;

    // Address of the last router
    localparam node_addr_t num_nodes = 3'd4;

    // Source address stamped on flits built at node 1
    localparam node_addr_t ingress_addr = 3'd1;

endpackage
